//--- alu.sv
`timescale 1ns/1ns

module alu (
    input  backend_pkg::alu_op_t         op_i,
    input  logic [backend_pkg::XLEN-1:0] a_i,
    input  logic [backend_pkg::XLEN-1:0] b_i,
    output logic [backend_pkg::XLEN-1:0] result_o
);

    logic [backend_pkg::SHAMT_W-1:0] shamt;

    assign shamt = b_i[backend_pkg::SHAMT_W-1:0];  // Low bits of b only

    always_comb begin
        unique case (op_i)
            backend_pkg::ALU_ADD:  result_o = a_i + b_i;
            backend_pkg::ALU_SUB:  result_o = a_i - b_i;
            backend_pkg::ALU_AND:  result_o = a_i & b_i;
            backend_pkg::ALU_OR:   result_o = a_i | b_i;
            backend_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            backend_pkg::ALU_SLT: begin
                result_o = ($signed(a_i) < $signed(b_i)) ? 32'd1 : 32'd0;
            end
            backend_pkg::ALU_SLTU: begin
                result_o = (a_i < b_i) ? 32'd1 : 32'd0;
            end
            backend_pkg::ALU_SLL:  result_o = a_i << shamt;
            backend_pkg::ALU_SRL:  result_o = a_i >> shamt;
            backend_pkg::ALU_LUI:  result_o = b_i;  // Operand b already holds imm
            default:               result_o = '0;
        endcase
    end

endmodule

//--- backend_pkg.sv
package backend_pkg;

    localparam int ISSUE_WIDTH    = 2;
    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_REGS       = 1 << REG_ADDR_W;
    localparam int NUM_READ_PORTS = ISSUE_WIDTH * 2;  // rs1 and rs2 for each lane
    localparam int SHAMT_W        = $clog2(XLEN);
    localparam int DEBUG_WEN_W    = 4;

    // ALU opcode encoding
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_LUI  = 4'd9   // Immediate passes straight through
    } alu_op_t;

    // Decoded micro-op as handed over by the decoder
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_t               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  use_imm;  // imm takes the place of rs2
        logic [XLEN-1:0]       imm;
    } uop_t;

    // Micro-op with its operands resolved
    typedef struct packed {
        uop_t            uop;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } issued_uop_t;

    // One lane's result
    typedef struct packed {
        logic                  valid;
        logic                  we;     // Set only for rd != 0
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       pc;
    } wb_t;

    // Debug commit port, same fields as debug*_wb_*
    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [DEBUG_WEN_W-1:0] wen;
        logic [REG_ADDR_W-1:0]  wnum;
        logic [XLEN-1:0]        wdata;
    } debug_commit_t;

endpackage

//--- backend_top.f
backend_pkg.sv
gpr_file.sv
issue_stage.sv
alu.sv
exec_stage.sv
commit_trace.sv
backend_top.sv
tb_backend_top.sv

//--- backend_top.sv
`timescale 1ns/1ns

module backend_top (
    input  logic                                                      clk,
    input  logic                                                      rst_i,
    input  backend_pkg::uop_t [backend_pkg::ISSUE_WIDTH-1:0]          uop_pair_i,
    output backend_pkg::debug_commit_t [backend_pkg::ISSUE_WIDTH-1:0] debug_o
);

    // Issue <-> register file
    logic [backend_pkg::NUM_READ_PORTS-1:0][backend_pkg::REG_ADDR_W-1:0] rf_raddr;
    logic [backend_pkg::NUM_READ_PORTS-1:0][backend_pkg::XLEN-1:0]       rf_rdata;

    backend_pkg::issued_uop_t [backend_pkg::ISSUE_WIDTH-1:0] issued;
    backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]         ex_wb;  // Also the forwarding source
    backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]         rf_wr;

    issue_stage u_issue_stage (
        .clk       (clk),
        .rst_i     (rst_i),
        .uop_pair_i(uop_pair_i),
        .fwd_i     (ex_wb),
        .raddr_o   (rf_raddr),
        .rdata_i   (rf_rdata),
        .issued_o  (issued)
    );

    gpr_file u_gpr_file (
        .clk    (clk),
        .wr_i   (rf_wr),
        .raddr_i(rf_raddr),
        .rdata_o(rf_rdata)
    );

    exec_stage u_exec_stage (
        .clk     (clk),
        .rst_i   (rst_i),
        .issued_i(issued),
        .ex_wb_o (ex_wb)
    );

    commit_trace u_commit_trace (
        .clk    (clk),
        .rst_i  (rst_i),
        .ex_wb_i(ex_wb),
        .rf_wr_o(rf_wr),
        .debug_o(debug_o)
    );

endmodule

//--- commit_trace.sv
`timescale 1ns/1ns

module commit_trace (
    input  logic                                                      clk,
    input  logic                                                      rst_i,
    input  backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]           ex_wb_i,
    output backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]           rf_wr_o,
    output backend_pkg::debug_commit_t [backend_pkg::ISSUE_WIDTH-1:0] debug_o
);

    backend_pkg::debug_commit_t [backend_pkg::ISSUE_WIDTH-1:0] debug_q;

    // Register file is written straight from ex_wb
    assign rf_wr_o = ex_wb_i;

    // Debug ports lag the write by one edge, like the commit trace of the core
    always_ff @(posedge clk) begin
        for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
            debug_q[i].pc    <= ex_wb_i[i].pc;
            debug_q[i].wnum  <= ex_wb_i[i].waddr;
            debug_q[i].wdata <= ex_wb_i[i].wdata;
            if (rst_i) begin
                debug_q[i].wen <= '0;
            end else begin
                debug_q[i].wen <= {{(backend_pkg::DEBUG_WEN_W-1){1'b0}}, ex_wb_i[i].we};
            end
        end
    end

    assign debug_o = debug_q;

endmodule

//--- exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
    input  logic                                                    clk,
    input  logic                                                    rst_i,
    input  backend_pkg::issued_uop_t [backend_pkg::ISSUE_WIDTH-1:0] issued_i,
    output backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]         ex_wb_o
);

    logic [backend_pkg::ISSUE_WIDTH-1:0][backend_pkg::XLEN-1:0] alu_res;
    logic [backend_pkg::XLEN-1:0] lane1_a;
    logic [backend_pkg::XLEN-1:0] lane1_b;
    logic                         lane0_writes;
    backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0] ex_wb_q;

    alu u_alu_0 (
        .op_i    (issued_i[0].uop.op),
        .a_i     (issued_i[0].rs1_val),
        .b_i     (issued_i[0].rs2_val),
        .result_o(alu_res[0])
    );

    assign lane0_writes = issued_i[0].uop.valid && issued_i[0].uop.rd != '0;

    // Lane 1 sees lane 0's result within the same cycle
    always_comb begin
        lane1_a = issued_i[1].rs1_val;
        lane1_b = issued_i[1].rs2_val;
        if (lane0_writes && issued_i[1].uop.rs1 == issued_i[0].uop.rd) begin
            lane1_a = alu_res[0];
        end
        if (lane0_writes && !issued_i[1].uop.use_imm &&
            issued_i[1].uop.rs2 == issued_i[0].uop.rd) begin
            lane1_b = alu_res[0];
        end
    end

    alu u_alu_1 (
        .op_i    (issued_i[1].uop.op),
        .a_i     (lane1_a),
        .b_i     (lane1_b),
        .result_o(alu_res[1])
    );

    always_ff @(posedge clk) begin
        for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
            ex_wb_q[i].waddr <= issued_i[i].uop.rd;
            ex_wb_q[i].wdata <= alu_res[i];
            ex_wb_q[i].pc    <= issued_i[i].uop.pc;
            if (rst_i) begin
                ex_wb_q[i].valid <= 1'b0;
                ex_wb_q[i].we    <= 1'b0;
            end else begin
                ex_wb_q[i].valid <= issued_i[i].uop.valid;
                ex_wb_q[i].we    <= issued_i[i].uop.valid && issued_i[i].uop.rd != '0;
            end
        end
    end

    assign ex_wb_o = ex_wb_q;

    // A write one cycle on must come from a valid issued lane
    for (genvar g = 0; g < backend_pkg::ISSUE_WIDTH; g++) begin : g_we_chk
        a_bubble_no_we : assert property (@(posedge clk) disable iff (rst_i)
            ex_wb_o[g].we |-> ex_wb_o[g].valid && $past(issued_i[g].uop.valid))
            else $error("exec_stage: write enable on bubble lane %0d", g);
    end

endmodule

//--- gpr_file.sv
`timescale 1ns/1ns

module gpr_file (
    input  logic                                                       clk,
    input  backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]            wr_i,
    input  logic [backend_pkg::NUM_READ_PORTS-1:0][backend_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [backend_pkg::NUM_READ_PORTS-1:0][backend_pkg::XLEN-1:0]       rdata_o
);

    // x0 has no storage
    logic [backend_pkg::XLEN-1:0] regs [1:backend_pkg::NUM_REGS-1];

    // Later lane is younger, so its write lands last
    always_ff @(posedge clk) begin
        for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
            if (wr_i[i].we && wr_i[i].waddr != '0) begin
                regs[wr_i[i].waddr] <= wr_i[i].wdata;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < backend_pkg::NUM_READ_PORTS; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;  // Hard-wired zero
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

    // Execute must never raise a write for x0
    for (genvar g = 0; g < backend_pkg::ISSUE_WIDTH; g++) begin : g_x0_chk
        a_no_x0_write : assert property (@(posedge clk)
            wr_i[g].we |-> wr_i[g].waddr != '0)
            else $error("gpr_file: write enable on x0, lane %0d", g);
    end

endmodule

//--- issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
    input  logic                                                    clk,
    input  logic                                                    rst_i,
    input  backend_pkg::uop_t [backend_pkg::ISSUE_WIDTH-1:0]        uop_pair_i,
    input  backend_pkg::wb_t [backend_pkg::ISSUE_WIDTH-1:0]         fwd_i,
    output logic [backend_pkg::NUM_READ_PORTS-1:0][backend_pkg::REG_ADDR_W-1:0] raddr_o,
    input  logic [backend_pkg::NUM_READ_PORTS-1:0][backend_pkg::XLEN-1:0]       rdata_i,
    output backend_pkg::issued_uop_t [backend_pkg::ISSUE_WIDTH-1:0] issued_o
);

    backend_pkg::uop_t [backend_pkg::ISSUE_WIDTH-1:0] pair_q;

    // Pair register, only the valid bits see reset
    always_ff @(posedge clk) begin
        pair_q <= uop_pair_i;
        if (rst_i) begin
            for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
                pair_q[i].valid <= 1'b0;
            end
        end
    end

    // Resolve one source against ex_wb, lane 1 checked last so it wins
    function automatic logic [backend_pkg::XLEN-1:0] fwd_value(
        input logic [backend_pkg::REG_ADDR_W-1:0] addr,
        input logic [backend_pkg::XLEN-1:0]       rf_val
    );
        logic [backend_pkg::XLEN-1:0] val;
        val = rf_val;
        for (int l = 0; l < backend_pkg::ISSUE_WIDTH; l++) begin
            if (fwd_i[l].valid && fwd_i[l].we && fwd_i[l].waddr == addr) begin
                val = fwd_i[l].wdata;
            end
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    always_comb begin
        for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
            raddr_o[2*i]     = pair_q[i].rs1;
            raddr_o[2*i + 1] = pair_q[i].rs2;
        end
    end

    always_comb begin
        for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
            issued_o[i].uop     = pair_q[i];
            issued_o[i].rs1_val = fwd_value(pair_q[i].rs1, rdata_i[2*i]);
            if (pair_q[i].use_imm) begin
                issued_o[i].rs2_val = pair_q[i].imm;
            end else begin
                issued_o[i].rs2_val = fwd_value(pair_q[i].rs2, rdata_i[2*i + 1]);
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_backend_top

verilator --binary --assert --top-module "$TOP" -f backend_top.f \
    --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

//--- tb_backend_top.sv
`timescale 1ns/1ns

module tb_backend_top;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int N_TESTS      = 6;
    localparam int INIT_PAIRS   = 16;
    localparam int OP_REPEAT    = 4;
    localparam int FWD_ROUNDS   = 8;
    localparam int INTRA_ROUNDS = 8;
    localparam int SAME_ROUNDS  = 8;
    localparam int STREAM_PAIRS = 200;
    localparam int DRAIN_CYCLES = 4;
    localparam int TEST_CYCLES  = RESET_CYCLES + 3 + INIT_PAIRS + 10 * OP_REPEAT
                                  + 2 * FWD_ROUNDS + INTRA_ROUNDS + 2 * SAME_ROUNDS
                                  + STREAM_PAIRS + (N_TESTS + 1) * DRAIN_CYCLES;
    localparam int MARGIN_NS    = 40 * CLK_PERIOD;

    // Expected commit of one pair
    typedef struct packed {
        logic                                                      chk;
        logic [7:0]                                                test;
        logic [backend_pkg::ISSUE_WIDTH-1:0]                       cmp_pc;
        logic [backend_pkg::ISSUE_WIDTH-1:0]                       cmp_data;
        backend_pkg::debug_commit_t [backend_pkg::ISSUE_WIDTH-1:0] dbg;
    } exp_rec_t;

    logic clk = 1'b0;
    logic rst_i;
    backend_pkg::uop_t [backend_pkg::ISSUE_WIDTH-1:0]          uop_pair_i;
    backend_pkg::debug_commit_t [backend_pkg::ISSUE_WIDTH-1:0] debug_o;

    logic [31:0] lcg_state = 32'h7aab5175;
    logic [31:0] pc_ctr = 32'h1c00_0000;
    logic [31:0] model_regs [backend_pkg::NUM_REGS];  // Architectural state in program order
    exp_rec_t    exp_q [$];
    exp_rec_t    exp_head = '0;                       // Record due on debug_o now
    int          cur_test = 0;
    int          checks_done [N_TESTS];
    int          checks_failed [N_TESTS];
    string       test_names [N_TESTS] = '{"reset", "alu_ops", "fwd_b2b",
                                          "intra_pair", "same_rd_x0", "stream"};

    backend_top UUT (
        .clk       (clk),
        .rst_i     (rst_i),
        .uop_pair_i(uop_pair_i),
        .debug_o   (debug_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);  // Fold high bits down
    endfunction

    function automatic backend_pkg::alu_op_t rand_op(input int n_ops);
        return backend_pkg::alu_op_t'(4'(next_rand() % 32'(n_ops)));
    endfunction

    // Valid micro-op with random fields and a nonzero rd
    function automatic backend_pkg::uop_t rand_uop(input backend_pkg::alu_op_t op);
        backend_pkg::uop_t u;
        logic [31:0]       rnd;
        rnd       = next_rand();
        u         = '0;
        u.valid   = 1'b1;
        u.op      = op;
        u.rd      = 5'(next_rand() % 32'd31) + 5'd1;
        u.rs1     = 5'(next_rand());
        u.rs2     = 5'(next_rand());
        u.use_imm = rnd[31] || op == backend_pkg::ALU_LUI;
        u.imm     = next_rand();
        return u;
    endfunction

    function automatic logic [31:0] model_alu(input backend_pkg::alu_op_t op,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        case (op)
            backend_pkg::ALU_ADD:  r = a + b;
            backend_pkg::ALU_SUB:  r = a + ~b + 32'd1;
            backend_pkg::ALU_AND:  r = a & b;
            backend_pkg::ALU_OR:   r = a | b;
            backend_pkg::ALU_XOR:  r = a ^ b;
            backend_pkg::ALU_SLT: begin
                if (a[31] != b[31]) begin
                    r = {31'd0, a[31]};  // Negative side is the smaller one
                end else begin
                    r = {31'd0, a < b};
                end
            end
            backend_pkg::ALU_SLTU: r = {31'd0, a < b};
            backend_pkg::ALU_SLL:  r = a << b[4:0];
            backend_pkg::ALU_SRL:  r = a >> b[4:0];
            backend_pkg::ALU_LUI:  r = b;
            default:               r = 32'd0;
        endcase
        return r;
    endfunction

    // Drive one pair after the edge and queue what it must commit
    task automatic step_pair(input backend_pkg::uop_t l0, input backend_pkg::uop_t l1);
        backend_pkg::uop_t [backend_pkg::ISSUE_WIDTH-1:0] lanes;
        exp_rec_t    rec;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        writes;
        logic        dropped;
        lanes[0] = l0;
        lanes[1] = l1;
        @(posedge clk);
        #1;
        dropped  = rst_i;  // Pair driven under reset is dropped by the issue register
        rec      = '0;
        rec.chk  = 1'b1;
        rec.test = 8'(cur_test);
        for (int i = 0; i < backend_pkg::ISSUE_WIDTH; i++) begin
            lanes[i].pc = pc_ctr;
            pc_ctr      = pc_ctr + 32'd4;
            a   = model_regs[lanes[i].rs1];
            b   = lanes[i].use_imm ? lanes[i].imm : model_regs[lanes[i].rs2];
            res = model_alu(lanes[i].op, a, b);
            writes = lanes[i].valid && lanes[i].rd != 5'd0 && !dropped;
            if (writes) begin
                model_regs[lanes[i].rd] = res;  // Lane 1 lands after lane 0
            end
            rec.dbg[i].pc    = lanes[i].pc;
            rec.dbg[i].wen   = {3'b000, writes};
            rec.dbg[i].wnum  = lanes[i].rd;
            rec.dbg[i].wdata = res;
            rec.cmp_pc[i]    = lanes[i].valid && !dropped;
            rec.cmp_data[i]  = writes;
        end
        uop_pair_i = lanes;
        exp_q.push_back(rec);
        if (exp_q.size() == 4) begin
            exp_head = exp_q.pop_front();
        end
    endtask

    task automatic finish_test();
        repeat (DRAIN_CYCLES) begin
            step_pair('0, '0);
        end
        $display("test %-10s checks %4d  failures %0d  %s", test_names[cur_test],
                 checks_done[cur_test], checks_failed[cur_test],
                 (checks_failed[cur_test] == 0) ? "ok" : "failed");
        cur_test++;
    endtask

    function automatic logic lane_matches(input int lane);
        backend_pkg::debug_commit_t e;
        backend_pkg::debug_commit_t a;
        logic ok;
        e  = exp_head.dbg[lane];
        a  = debug_o[lane];
        ok = (a.wen === e.wen);
        if (exp_head.cmp_pc[lane]) begin
            ok = ok && (a.pc === e.pc);
        end
        if (exp_head.cmp_data[lane]) begin
            ok = ok && (a.wnum === e.wnum) && (a.wdata === e.wdata);
        end
        return ok;
    endfunction

    task automatic report_mismatch(input int lane);
        backend_pkg::debug_commit_t e;
        backend_pkg::debug_commit_t a;
        string                      exp_s;
        string                      act_s;
        e = exp_head.dbg[lane];
        a = debug_o[lane];
        checks_failed[exp_head.test]++;
        exp_s = $sformatf("pc=%h wen=%h wnum=%0d wdata=%h", e.pc, e.wen, e.wnum, e.wdata);
        act_s = $sformatf("pc=%h wen=%h wnum=%0d wdata=%h", a.pc, a.wen, a.wnum, a.wdata);
        $display("CHECK FAILED %s lane %0d: expected %s actual %s",
                 test_names[exp_head.test], lane, exp_s, act_s);
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    for (genvar g = 0; g < backend_pkg::ISSUE_WIDTH; g++) begin : g_commit_chk
        a_commit : assert property (@(negedge clk) exp_head.chk |-> lane_matches(g))
            else report_mismatch(g);
    end

    a_reset_quiet : assert property (@(negedge clk)
        rst_i |-> debug_o[0].wen == '0 && debug_o[1].wen == '0)
        else begin
            checks_failed[0]++;
            $display("Reset check: a debug write enable is set while reset is held");
        end

    always @(negedge clk) begin
        if (exp_head.chk) begin
            checks_done[exp_head.test] += backend_pkg::ISSUE_WIDTH;
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog: run did not finish within %0d ns, stopping",
                 TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        backend_pkg::uop_t l0;
        backend_pkg::uop_t l1;
        backend_pkg::uop_t p0;
        backend_pkg::uop_t p1;
        int                total_fail;
        int                tests_ok;
        for (int r = 0; r < backend_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        rst_i      = 1'b1;
        uop_pair_i = '0;

        // Valid pairs offered under reset must never commit
        repeat (RESET_CYCLES - 1) begin
            l0 = rand_uop(rand_op(10));
            l1 = rand_uop(rand_op(10));
            step_pair(l0, l1);
        end
        step_pair('0, '0);  // Captured after release
        rst_i = 1'b0;
        repeat (3) begin
            step_pair('0, '0);
        end
        finish_test();

        // Fill every register before anything reads it
        for (int i = 0; i < INIT_PAIRS; i++) begin
            l0    = rand_uop(backend_pkg::ALU_LUI);
            l1    = rand_uop(backend_pkg::ALU_LUI);
            l0.rd = 5'(2 * i + 1);
            l1.rd = 5'(2 * i + 2);  // Last one wraps to x0
            step_pair(l0, l1);
        end
        for (int op = 0; op < 10; op++) begin
            repeat (OP_REPEAT) begin
                l0 = rand_uop(backend_pkg::alu_op_t'(4'(op)));
                l1 = rand_uop(backend_pkg::alu_op_t'(4'(op)));
                step_pair(l0, l1);
            end
        end
        finish_test();

        // Sources taken from the pair just ahead
        for (int i = 0; i < FWD_ROUNDS; i++) begin
            p0    = rand_uop(rand_op(10));
            p1    = rand_uop(rand_op(10));
            p1.rd = (p0.rd == 5'd31) ? 5'd1 : p0.rd + 5'd1;
            step_pair(p0, p1);
            l0         = rand_uop(rand_op(9));
            l1         = rand_uop(rand_op(9));
            l0.rs1     = p0.rd;
            l0.rs2     = p1.rd;
            l0.use_imm = 1'b0;
            l1.rs1     = p1.rd;
            l1.rs2     = p0.rd;
            l1.use_imm = 1'b0;
            step_pair(l0, l1);
        end
        finish_test();

        for (int i = 0; i < INTRA_ROUNDS; i++) begin
            l0         = rand_uop(rand_op(10));
            l1         = rand_uop(rand_op(9));
            l1.rs1     = l0.rd;
            l1.rs2     = l0.rd;
            l1.use_imm = (i % 2 == 1);
            step_pair(l0, l1);
        end
        finish_test();

        // Same rd on both lanes, then read it back next to an x0 write
        for (int i = 0; i < SAME_ROUNDS; i++) begin
            l0    = rand_uop(rand_op(10));
            l1    = rand_uop(rand_op(10));
            l1.rd = l0.rd;
            step_pair(l0, l1);
            p0         = rand_uop(backend_pkg::ALU_ADD);
            p0.rs1     = l0.rd;
            p0.rs2     = 5'd0;
            p0.use_imm = 1'b0;
            p1         = rand_uop(rand_op(10));
            p1.rd      = 5'd0;
            step_pair(p0, p1);
        end
        finish_test();

        for (int i = 0; i < STREAM_PAIRS; i++) begin
            l0    = rand_uop(rand_op(10));
            l1    = rand_uop(rand_op(10));
            l0.rd = 5'(next_rand());
            l1.rd = 5'(next_rand());
            if (next_rand() % 32'd4 == 32'd0) begin
                l0.valid = 1'b0;
            end
            if (next_rand() % 32'd4 == 32'd0) begin
                l1.valid = 1'b0;
            end
            step_pair(l0, l1);
        end
        finish_test();

        total_fail = 0;
        tests_ok   = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_fail += checks_failed[t];
            if (checks_failed[t] == 0 && checks_done[t] > 0) begin
                tests_ok++;
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check failures",
                 N_TESTS, tests_ok, N_TESTS - tests_ok, total_fail);
        if (tests_ok == N_TESTS) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
